/* src/imul_config.svh */
//--------------------
// width settings for the iterative multiplier
// include wherever the operand width or step count is needed
//--------------------

`ifndef IMUL_CONFIG_SVH
`define IMUL_CONFIG_SVH

// operand width in bits and half the product width
`define IMUL_WIDTH 32

// one shift-and-add step per multiplier bit
`define IMUL_STEPS `IMUL_WIDTH

`endif

/* src/imul_pkg.sv */
//--------------------
// shared types for the iterative multiplier
// datapath, control unit and bench all pull from here
//--------------------

`default_nettype none

`include "imul_config.svh"

package imul_pkg;

  // one signed request operand
  typedef logic signed [`IMUL_WIDTH-1:0] operand_t;

  // full precision signed product two words wide
  typedef logic signed [2*`IMUL_WIDTH-1:0] result_t;

  // step counter with one extra bit so the full step count fits
  typedef logic [$clog2(`IMUL_STEPS):0] step_t;

  //--------------------
  // control FSM states
  //--------------------
  // IDLE  waiting for a request with mulreq_rdy high
  // CALC  one shift-and-add step per cycle
  // DONE  product offered on the response port
  typedef enum logic [1:0] {
    IDLE = 2'd0,
    CALC = 2'd1,
    DONE = 2'd2
  } ctrl_state_t;

endpackage

`default_nettype wire

/* src/imul_dpath.sv */
//--------------------
// multiplier datapath that holds the operands and does the add and shift work
// load and step come from the control unit and the FSM state stays hidden here
//--------------------

`timescale 1ns/1ps
`default_nettype none

`include "imul_config.svh"

module imul_dpath (
  input  wire                clk,
  input  wire                reset,

  // request operands sampled only on load
  input  imul_pkg::operand_t mulreq_a,
  input  imul_pkg::operand_t mulreq_b,

  // enables from the control unit
  input  wire                load,
  input  wire                step,

  // signed product valid once the control unit reaches DONE
  output imul_pkg::result_t  mulresp_result
);

  import imul_pkg::*;

  //--------------------
  // operand magnitudes
  //--------------------

  // sign bits of the incoming operands
  logic sign_a;
  logic sign_b;

  // unsigned magnitudes where the most negative value maps to 2**(width-1)
  logic [`IMUL_WIDTH-1:0] mag_a;
  logic [`IMUL_WIDTH-1:0] mag_b;

  assign sign_a = mulreq_a[`IMUL_WIDTH-1];
  assign sign_b = mulreq_b[`IMUL_WIDTH-1];

  // twos complement negate when the sign bit is set
  assign mag_a = sign_a ? (~mulreq_a + 1'b1) : mulreq_a;
  assign mag_b = sign_b ? (~mulreq_b + 1'b1) : mulreq_b;

  //--------------------
  // working registers
  //--------------------

  // multiplicand zero extended to product width and shifted left each step
  logic [2*`IMUL_WIDTH-1:0] mcand_reg;

  // multiplier shifted right each step with bit 0 deciding the add
  logic [`IMUL_WIDTH-1:0]   mplier_reg;

  // running unsigned sum of partial products
  logic [2*`IMUL_WIDTH-1:0] acc_reg;

  // set when exactly one operand was negative
  logic                     neg_reg;

  //--------------------
  // step logic
  //--------------------

  // next accumulator value for this step
  logic [2*`IMUL_WIDTH-1:0] acc_sum;

  // only add the multiplicand when the low multiplier bit is set
  assign acc_sum = mplier_reg[0] ? (acc_reg + mcand_reg) : acc_reg;

  // operand shift registers loaded on the accept edge
  always_ff @(posedge clk) begin
    if (load) begin
      mcand_reg  <= {{`IMUL_WIDTH{1'b0}}, mag_a};
      mplier_reg <= mag_b;
    end else if (step) begin
      // walk to the next partial product
      mcand_reg  <= mcand_reg << 1;
      mplier_reg <= mplier_reg >> 1;
    end
  end

  // accumulator and result sign
  always_ff @(posedge clk) begin
    if (reset) begin
      acc_reg <= '0;
      neg_reg <= 1'b0;
    end else if (load) begin
      // fresh product with the sign decided up front
      acc_reg <= '0;
      neg_reg <= sign_a ^ sign_b;
    end else if (step) begin
      acc_reg <= acc_sum;
    end
  end

  //--------------------
  // output sign fix
  //--------------------

  // unsigned product viewed as the signed result type
  result_t mag_result;

  assign mag_result = result_t'(acc_reg);

  // combinational from registers so no cycle is added
  // held stable in DONE since step and load are both low there
  assign mulresp_result = neg_reg ? -mag_result : mag_result;

endmodule

`default_nettype wire

/* src/imul_ctrl.sv */
//--------------------
// control unit for the iterative multiplier
// IDLE/CALC/DONE FSM that drives the handshakes and datapath enables
//--------------------

`timescale 1ns/1ps
`default_nettype none

`include "imul_config.svh"

module imul_ctrl (
  input  wire  clk,
  input  wire  reset,

  // request handshake
  input  wire  mulreq_val,
  output logic mulreq_rdy,

  // response handshake
  output logic mulresp_val,
  input  wire  mulresp_rdy,

  // datapath enables
  output logic load,
  output logic step
);

  import imul_pkg::*;

  ctrl_state_t state;

  // CALC cycle count from 0 up to steps minus one
  step_t       count;

  // transfer conditions on each port
  logic        req_go;
  logic        resp_go;

  assign req_go  = mulreq_val && mulreq_rdy;
  assign resp_go = mulresp_val && mulresp_rdy;

  //--------------------
  // state register
  //--------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= IDLE;
      count <= '0;
    end else begin
      case (state)
        IDLE: begin
          // accept edge starts counting from zero
          if (req_go) begin
            state <= CALC;
            count <= '0;
          end
        end
        CALC: begin
          // last step happens on the edge that leaves CALC
          if (count == step_t'(`IMUL_STEPS - 1)) begin
            state <= DONE;
          end else begin
            count <= count + 1'b1;
          end
        end
        DONE: begin
          // hold until the response is taken
          if (resp_go) begin
            state <= IDLE;
          end
        end
        default: begin
          // recover to IDLE from the unused encoding
          state <= IDLE;
        end
      endcase
    end
  end

  //--------------------
  // output decode
  //--------------------

  // outputs follow the state alone except load which also needs mulreq_val
  always_comb begin
    mulreq_rdy  = 1'b0;
    mulresp_val = 1'b0;
    load        = 1'b0;
    step        = 1'b0;
    case (state)
      IDLE: begin
        mulreq_rdy = 1'b1;
        // capture operands on the accept edge only
        load       = mulreq_val;
      end
      CALC: begin
        // one add and shift per cycle with mulreq_val ignored
        step = 1'b1;
      end
      DONE: begin
        mulresp_val = 1'b1;
      end
      default: begin
        mulreq_rdy = 1'b0;
      end
    endcase
  end

endmodule

`default_nettype wire

/* src/imul_iterative.sv */
//--------------------
// top level of the iterative 32x32 signed multiplier
// one request in flight with the product after a fixed 32 steps
//--------------------

`timescale 1ns/1ps
`default_nettype none

module imul_iterative (
  input  wire                clk,
  input  wire                reset,

  // request port
  input  imul_pkg::operand_t mulreq_a,
  input  imul_pkg::operand_t mulreq_b,
  input  wire                mulreq_val,
  output logic               mulreq_rdy,

  // response port
  output imul_pkg::result_t  mulresp_result,
  output logic               mulresp_val,
  input  wire                mulresp_rdy
);

  // enables from control to datapath
  logic load;
  logic step;

  // operand storage and add/shift work
  imul_dpath dpath (
    .clk            (clk),
    .reset          (reset),
    .mulreq_a       (mulreq_a),
    .mulreq_b       (mulreq_b),
    .load           (load),
    .step           (step),
    .mulresp_result (mulresp_result)
  );

  // decides which registers move each cycle
  imul_ctrl ctrl (
    .clk         (clk),
    .reset       (reset),
    .mulreq_val  (mulreq_val),
    .mulreq_rdy  (mulreq_rdy),
    .mulresp_val (mulresp_val),
    .mulresp_rdy (mulresp_rdy),
    .load        (load),
    .step        (step)
  );

endmodule

`default_nettype wire

/* bench/imul_assert.sv */
//--------------------
// handshake and stability assertions for the multiplier top level
// attached to imul_iterative by the bind at the end of this file
//--------------------

`timescale 1ns/1ps
`default_nettype none

`include "imul_config.svh"

module imul_assert (
  input wire               clk,
  input wire               reset,
  input wire               mulreq_val,
  input wire               mulreq_rdy,
  input wire               mulresp_val,
  input wire               mulresp_rdy,
  input imul_pkg::result_t mulresp_result
);

  // edges since the last request transfer saturating at all ones
  logic [7:0] since_req;

  always_ff @(posedge clk) begin
    if (reset) begin
      since_req <= 8'hff;
    end else if (mulreq_val && mulreq_rdy) begin
      since_req <= 8'd0;
    end else if (since_req != 8'hff) begin
      since_req <= since_req + 8'd1;
    end
  end

  // request and response sides never open at once
  rdy_val_excl: assert property (@(posedge clk) disable iff (reset)
    !(mulreq_rdy && mulresp_val))
    else $error("mulreq_rdy and mulresp_val high together");

  // offered response holds until taken
  resp_hold: assert property (@(posedge clk) disable iff (reset)
    (mulresp_val && !mulresp_rdy) |=> (mulresp_val && $stable(mulresp_result)))
    else $error("response dropped or changed under back-pressure");

  // idle right after any reset cycle
  reset_state: assert property (@(posedge clk)
    reset |=> (mulreq_rdy && !mulresp_val))
    else $error("unit not idle after reset");

  // fixed latency from accept edge to first cycle of mulresp_val
  resp_latency: assert property (@(posedge clk) disable iff (reset)
    $rose(mulresp_val) |-> (since_req == 8'(`IMUL_STEPS)))
    else $error("mulresp_val rose at the wrong cycle after the request");

endmodule

bind imul_iterative imul_assert u_assert (
  .clk            (clk),
  .reset          (reset),
  .mulreq_val     (mulreq_val),
  .mulreq_rdy     (mulreq_rdy),
  .mulresp_val    (mulresp_val),
  .mulresp_rdy    (mulresp_rdy),
  .mulresp_result (mulresp_result)
);

`default_nettype wire

/* bench/imul_tb.sv */
//--------------------
// testbench for the iterative signed multiplier
// runs a table of operand pairs with back-pressure and spurious requests
//--------------------

`timescale 1ns/1ps
`default_nettype none

`include "imul_config.svh"

module imul_tb;

  import imul_pkg::*;

  localparam int PERIOD  = 4;
  localparam int NTESTS  = 17;
  localparam int NFIXED  = 9;
  localparam int MAX_BP  = 5;
  // worst case steps, back-pressure and slack for every test plus the reset cycles
  localparam int WATCHDOG_NS = (NTESTS * (`IMUL_STEPS + MAX_BP + 10) + 4) * PERIOD;

  logic     clk;
  logic     reset;
  operand_t mulreq_a;
  operand_t mulreq_b;
  logic     mulreq_val;
  logic     mulreq_rdy;
  result_t  mulresp_result;
  logic     mulresp_val;
  logic     mulresp_rdy;

  //--------------------
  // stimulus table
  //--------------------
  string    t_name [NTESTS];
  operand_t t_a    [NTESTS];
  operand_t t_b    [NTESTS];
  int       t_bp   [NTESTS];
  logic     t_spur [NTESTS];

  int          n_pass;
  int          n_fail;

  imul_iterative UUT (
    .clk            (clk),
    .reset          (reset),
    .mulreq_a       (mulreq_a),
    .mulreq_b       (mulreq_b),
    .mulreq_val     (mulreq_val),
    .mulreq_rdy     (mulreq_rdy),
    .mulresp_result (mulresp_result),
    .mulresp_val    (mulresp_val),
    .mulresp_rdy    (mulresp_rdy)
  );

  initial begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

  // full precision reference with both sides sign extended first
  function automatic result_t signed_product(input operand_t a, input operand_t b);
    result_t wa;
    result_t wb;
    wa = a;
    wb = b;
    return wa * wb;
  endfunction

  //--------------------
  // compare tasks
  //--------------------
  task automatic check_result(input string name, input result_t exp, input result_t act);
    if (act !== exp) begin
      $display("FAIL %s expected %0d actual %0d", name, exp, act);
      n_fail++;
    end else begin
      n_pass++;
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("FAIL %s expected %b actual %b", name, exp, act);
      n_fail++;
    end else begin
      n_pass++;
    end
  endtask

  task automatic check_latency(input string name, input int exp, input int act);
    if (act != exp) begin
      $display("FAIL %s expected %0d actual %0d", name, exp, act);
      n_fail++;
    end else begin
      n_pass++;
    end
  endtask

  // one fixed table row
  task automatic set_entry(
    input int       i,
    input string    name,
    input operand_t a,
    input operand_t b
  );
    t_name[i] = name;
    t_a[i]    = a;
    t_b[i]    = b;
  endtask

  // fixed corner cases first and random pairs from the seeded generator after them
  task automatic fill_table();
    set_entry(0, "zero",    0,             12345);
    set_entry(1, "one",     1,             -987654);
    set_entry(2, "pos_pos", 46341,         46340);
    set_entry(3, "neg_pos", -300,          70000);
    set_entry(4, "pos_neg", 123456,        -654321);
    set_entry(5, "neg_neg", -1000,         -2000);
    set_entry(6, "m1_m1",   -1,            -1);
    set_entry(7, "min_sq",  32'h8000_0000, 32'h8000_0000);
    set_entry(8, "min_one", 32'h8000_0000, 1);
    for (int i = 0; i < NFIXED; i++) begin
      // spread back-pressure and spurious requests over the corners
      t_bp[i]   = i % (MAX_BP + 1);
      t_spur[i] = (i % 2 == 0);
    end
    for (int i = NFIXED; i < NTESTS; i++) begin
      t_name[i] = $sformatf("rand_%0d", i - NFIXED);
      t_a[i]    = operand_t'($urandom);
      t_b[i]    = operand_t'($urandom);
      t_bp[i]   = $urandom_range(MAX_BP, 0);
      t_spur[i] = $urandom_range(1, 0);
    end
  endtask

  //--------------------
  // one table entry entered and left 1 ns after a rising edge
  //--------------------
  task automatic run_one(input int i);
    result_t exp;
    int      lat;
    int      fails_before;
    logic    rdy_seen;
    fails_before = n_fail;
    exp = signed_product(t_a[i], t_b[i]);
    mulreq_a   = t_a[i];
    mulreq_b   = t_b[i];
    mulreq_val = 1'b1;
    // idle on entry so the back-to-back request goes in this cycle
    check_flag({t_name[i], "_rdy_idle"}, 1'b1, mulreq_rdy);
    while (!mulreq_rdy) begin
      @(posedge clk);
      #1;
    end
    // accept edge
    @(posedge clk);
    #1;
    if (t_spur[i]) begin
      // new operands offered while busy must be ignored
      mulreq_a = t_a[i] ^ 32'h5a5a_5a5a;
      mulreq_b = t_b[i] + 7;
    end else begin
      mulreq_val = 1'b0;
    end
    lat = 0;
    rdy_seen = 1'b0;
    while (!mulresp_val) begin
      rdy_seen = rdy_seen | mulreq_rdy;
      @(posedge clk);
      #1;
      lat++;
    end
    mulreq_val = 1'b0;
    check_latency({t_name[i], "_latency"}, `IMUL_STEPS, lat);
    check_flag({t_name[i], "_rdy_calc"}, 1'b0, rdy_seen);
    // response must hold under back-pressure
    for (int k = 0; k < t_bp[i]; k++) begin
      check_flag({t_name[i], "_hold_val"}, 1'b1, mulresp_val);
      check_flag({t_name[i], "_hold_rdy"}, 1'b0, mulreq_rdy);
      check_result({t_name[i], "_hold"}, exp, mulresp_result);
      @(posedge clk);
      #1;
    end
    mulresp_rdy = 1'b1;
    check_flag({t_name[i], "_resp_val"}, 1'b1, mulresp_val);
    check_result(t_name[i], exp, mulresp_result);
    // response transfer edge
    @(posedge clk);
    #1;
    mulresp_rdy = 1'b0;
    check_flag({t_name[i], "_rdy_after"}, 1'b1, mulreq_rdy);
    if (n_fail == fails_before) begin
      $display("test %0d %s ok", i, t_name[i]);
    end else begin
      $display("test %0d %s had %0d errors", i, t_name[i], n_fail - fails_before);
    end
  endtask

  initial begin
    void'($urandom(29));
    n_pass      = 0;
    n_fail      = 0;
    reset       = 1'b1;
    mulreq_a    = '0;
    mulreq_b    = '0;
    mulreq_val  = 1'b0;
    mulresp_rdy = 1'b0;
    fork
      begin
        #(WATCHDOG_NS);
        $display("timeout: multiplier did not finish within %0d ns", WATCHDOG_NS);
        $display("CHECKS FAILED");
        $finish;
      end
    join_none
    fill_table();
    repeat (2) @(posedge clk);
    #1;
    reset = 1'b0;
    @(posedge clk);
    #1;
    check_flag("reset_rdy", 1'b1, mulreq_rdy);
    check_flag("reset_val", 1'b0, mulresp_val);
    for (int i = 0; i < NTESTS; i++) begin
      run_one(i);
    end
    $display("summary: %0d passed, %0d failed", n_pass, n_fail);
    if (n_fail == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* sources.f */
+incdir+src
src/imul_pkg.sv
src/imul_dpath.sv
src/imul_ctrl.sv
src/imul_iterative.sv
bench/imul_assert.sv
bench/imul_tb.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the multiplier testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module imul_tb \
  -f sources.f \
  --Mdir obj_dir -o imul_sim

# a failing assertion may stop the run early, keep going to inspect the log
if ./obj_dir/imul_sim > sim.log 2>&1; then
  sim_status=0
else
  sim_status=1
fi

cat sim.log

if grep -q "CHECKS FAILED" sim.log || [ "$sim_status" -ne 0 ] \
  || ! grep -q "ALL CHECKS PASSED" sim.log; then
  echo "simulation reported errors"
  exit 1
fi

echo "simulation clean"
